//--- Bender.yml
package:
  name: memSubsys

sources:
  - src/memPkg.sv
  - src/byteRam.sv
  - src/memCtrl.sv
  - src/instFetch.sv
  - src/memSubsys.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/memSubsys_props.sv
      - tests/memSubsysTb.sv

//--- list.f
src/memPkg.sv
src/byteRam.sv
src/memCtrl.sv
src/instFetch.sv
src/memSubsys.sv
tests/clockGen.sv
tests/memSubsys_props.sv
tests/memSubsysTb.sv

//--- src/byteRam.sv
`timescale 1ns/1ps

module byteRam #(
    parameter int ramAddrBits = 12
) (
    input  logic         clk,
    input  memPkg::ramReq ram,
    output memPkg::byteT  rdata
);

    localparam int depth = 2 ** ramAddrBits;

    memPkg::byteT mem [depth];
    logic [ramAddrBits-1:0] index;

    // only the low address bits select a byte
    assign index = ram.addr[ramAddrBits-1:0];

    always_ff @(posedge clk) begin
        if (ram.we) begin
            mem[index] <= ram.wdata;
        end
    end

    // registered read, old contents on a write to the same byte
    always_ff @(posedge clk) begin
        rdata <= mem[index];
    end

endmodule

//--- src/instFetch.sv
`timescale 1ns/1ps

module instFetch #(
    parameter memPkg::addrT resetPc = '0
) (
    input  logic         clk,
    input  logic         rst,

    input  logic         redirectValid,
    input  memPkg::addrT redirectPc,

    output logic         fetchValid,
    input  logic         fetchReady,
    output memPkg::addrT fetchAddr,
    input  logic         fetchDone,
    input  memPkg::wordT fetchWord,

    output logic         instValid,
    input  logic         instReady,
    output memPkg::wordT instWord,
    output memPkg::addrT instPc
);

    memPkg::addrT pc;
    memPkg::addrT flightPc;
    memPkg::wordT holdWord;
    memPkg::addrT holdPc;
    logic running;
    logic inflight;
    logic drop;
    logic holdValid;
    logic fetchFire;

    // one fetch at a time, and only into an empty holding register
    assign fetchValid = running && !inflight && !holdValid;
    assign fetchAddr  = pc;
    assign fetchFire  = fetchValid && fetchReady;

    assign instValid = holdValid;
    assign instWord  = holdWord;
    assign instPc    = holdPc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= resetPc;
            running   <= 1'b0;
            inflight  <= 1'b0;
            drop      <= 1'b0;
            holdValid <= 1'b0;
        end else begin
            if (fetchFire) begin
                inflight <= 1'b1;
                pc       <= pc + 32'd4;
            end
            if (fetchDone) begin
                inflight <= 1'b0;
                drop     <= 1'b0;
            end
            if (instValid && instReady) begin
                holdValid <= 1'b0;
            end
            if (fetchDone && !drop) begin
                holdValid <= 1'b1;
            end
            // redirect wins over everything above
            if (redirectValid) begin
                running   <= 1'b1;
                pc        <= redirectPc;
                holdValid <= 1'b0;
                drop      <= (inflight && !fetchDone) || fetchFire;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchFire) begin
            flightPc <= pc;
        end
        if (fetchDone && !drop) begin
            holdWord <= fetchWord;
            holdPc   <= flightPc;
        end
    end

endmodule

//--- src/memCtrl.sv
`timescale 1ns/1ps

module memCtrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           ioFull,

    input  logic           dataValid,
    output logic           dataReady,
    input  memPkg::dataReq dataIn,
    output logic           dataDone,
    output memPkg::wordT   rdata,

    input  logic           fetchValid,
    output logic           fetchReady,
    input  memPkg::addrT   fetchAddr,
    output logic           fetchDone,
    output memPkg::wordT   fetchWord,

    output memPkg::ramReq  ram,
    input  memPkg::byteT   ramRdata
);

    memPkg::ctrlState state;
    logic [2:0] stage;
    logic [2:0] count;
    memPkg::addrT baseAddr;
    memPkg::addrT curAddr;
    memPkg::addrT prevAddr;
    memPkg::wordT shiftReg;
    memPkg::wordT assembled;
    logic lastRead;

    function automatic logic [2:0] lenBytes(memPkg::accessLen len);
        logic [2:0] n;
        case (len)
            memPkg::lenByte: n = 3'd1;
            memPkg::lenHalf: n = 3'd2;
            default: n = 3'd4;
        endcase
        return n;
    endfunction

    // no request is taken while reset is active
    assign dataReady  = (state == memPkg::idle) && !ioFull && !rst;
    assign fetchReady = (state == memPkg::idle) && !ioFull && !rst && !dataValid;

    assign curAddr = baseAddr + {29'b0, stage};

    // stage == count is the cycle that sees the final byte
    assign lastRead = (stage == count) && !ioFull;

    // merge the last byte and zero-extend
    always_comb begin
        case (count)
            3'd1: assembled = {24'b0, ramRdata};
            3'd2: assembled = {16'b0, ramRdata, shiftReg[31:24]};
            default: assembled = {ramRdata, shiftReg[31:8]};
        endcase
    end

    assign dataDone  = (state == memPkg::readData) && lastRead;
    assign fetchDone = (state == memPkg::readInst) && lastRead;
    assign rdata     = assembled;
    assign fetchWord = assembled;

    // during a stall keep reading the byte that is due next
    always_comb begin
        ram.we    = (state == memPkg::writeData) && !ioFull;
        ram.addr  = ioFull ? prevAddr : curAddr;
        ram.wdata = shiftReg[7:0];
    end

    always_ff @(posedge clk) begin
        if (!ioFull) begin
            prevAddr <= ram.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::idle;
            stage <= 3'd0;
            count <= 3'd0;
        end else if (!ioFull) begin
            case (state)
                memPkg::idle: begin
                    stage <= 3'd0;
                    if (dataValid) begin
                        state <= dataIn.isStore ? memPkg::writeData : memPkg::readData;
                        count <= lenBytes(dataIn.len);
                    end else if (fetchValid) begin
                        state <= memPkg::readInst;
                        count <= 3'd4;
                    end
                end
                memPkg::readInst, memPkg::readData: begin
                    if (stage == count) begin
                        state <= memPkg::idle;
                        stage <= 3'd0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                memPkg::writeData: begin
                    if (stage + 3'd1 == count) begin
                        state <= memPkg::idle;
                        stage <= 3'd0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: state <= memPkg::idle;
            endcase
        end
    end

    // address and byte shifter
    always_ff @(posedge clk) begin
        if (!ioFull) begin
            case (state)
                memPkg::idle: begin
                    if (dataValid) begin
                        baseAddr <= dataIn.addr;
                        shiftReg <= dataIn.wdata;
                    end else if (fetchValid) begin
                        baseAddr <= fetchAddr;
                    end
                end
                memPkg::readInst, memPkg::readData: begin
                    // bytes enter at the top, so the low byte ends lowest
                    if (stage != 3'd0 && stage != count) begin
                        shiftReg <= {ramRdata, shiftReg[31:8]};
                    end
                end
                memPkg::writeData: begin
                    shiftReg <= {8'b0, shiftReg[31:8]};
                end
                default: ;
            endcase
        end
    end

endmodule

//--- src/memPkg.sv
package memPkg;

    // byte address and word data
    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;
    typedef logic [7:0] byteT;

    // number of bytes in a data access
    typedef enum logic [1:0] {
        lenByte = 2'd0,
        lenHalf = 2'd1,
        lenWord = 2'd2
    } accessLen;

    // controller sequencing state
    typedef enum logic [1:0] {
        idle      = 2'd0,
        readInst  = 2'd1,
        readData  = 2'd2,
        writeData = 2'd3
    } ctrlState;

    // load or store from the data client
    typedef struct packed {
        logic     isStore;
        accessLen len;
        addrT     addr;
        wordT     wdata;
    } dataReq;

    // per-cycle command to the byte RAM
    typedef struct packed {
        logic we;
        addrT addr;
        byteT wdata;
    } ramReq;

endpackage

//--- src/memSubsys.sv
`timescale 1ns/1ps

module memSubsys #(
    parameter int           ramAddrBits = 12,
    parameter memPkg::addrT resetPc     = '0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           ioFull,

    input  logic           dataValid,
    output logic           dataReady,
    input  memPkg::dataReq dataIn,
    output logic           dataDone,
    output memPkg::wordT   rdata,

    input  logic           redirectValid,
    input  memPkg::addrT   redirectPc,

    output logic           instValid,
    input  logic           instReady,
    output memPkg::wordT   instWord,
    output memPkg::addrT   instPc
);

    // fetch path between instFetch and memCtrl
    logic fetchValid;
    logic fetchReady;
    memPkg::addrT fetchAddr;
    logic fetchDone;
    memPkg::wordT fetchWord;

    memPkg::ramReq ramCmd;
    memPkg::byteT ramRdata;

    memCtrl memCtrl_inst (
        .clk        (clk),
        .rst        (rst),
        .ioFull     (ioFull),
        .dataValid  (dataValid),
        .dataReady  (dataReady),
        .dataIn     (dataIn),
        .dataDone   (dataDone),
        .rdata      (rdata),
        .fetchValid (fetchValid),
        .fetchReady (fetchReady),
        .fetchAddr  (fetchAddr),
        .fetchDone  (fetchDone),
        .fetchWord  (fetchWord),
        .ram        (ramCmd),
        .ramRdata   (ramRdata)
    );

    byteRam #(
        .ramAddrBits (ramAddrBits)
    ) byteRam_inst (
        .clk   (clk),
        .ram   (ramCmd),
        .rdata (ramRdata)
    );

    instFetch #(
        .resetPc (resetPc)
    ) instFetch_inst (
        .clk           (clk),
        .rst           (rst),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .fetchValid    (fetchValid),
        .fetchReady    (fetchReady),
        .fetchAddr     (fetchAddr),
        .fetchDone     (fetchDone),
        .fetchWord     (fetchWord),
        .instValid     (instValid),
        .instReady     (instReady),
        .instWord      (instWord),
        .instPc        (instPc)
    );

endmodule

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held over 8 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tests/memSubsysTb.sv
`timescale 1ns/1ps

module memSubsysTb;

    logic clk;
    logic rst;
    logic ioFull;
    logic dataValid;
    logic dataReady;
    memPkg::dataReq dataIn;
    logic dataDone;
    memPkg::wordT rdata;
    logic redirectValid;
    memPkg::addrT redirectPc;
    logic instValid;
    logic instReady;
    memPkg::wordT instWord;
    memPkg::addrT instPc;

    // reference copy of the RAM
    memPkg::byteT model [4096];
    logic [31:0] seed = 32'd9;
    int errors = 0;
    int limit = 200;

    clockGen clockGen_inst (.clk(clk), .rst(rst));

    memSubsys #(.ramAddrBits(12), .resetPc(32'h0)) memSubsys_inst (.*);

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int numBytes(memPkg::accessLen len);
        return (len == memPkg::lenByte) ? 1 : (len == memPkg::lenHalf) ? 2 : 4;
    endfunction

    // little-endian, zero-extended
    function automatic memPkg::wordT modelRead(memPkg::addrT addr, int n);
        memPkg::wordT w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = model[addr[11:0] + i];
        end
        return w;
    endfunction

    task automatic abortRun(string what);
        $display("timeout while waiting for %s", what);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic checkValue(string what, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // called right after a falling edge, returns after the handshake
    task automatic sendReq(logic write, memPkg::accessLen len, memPkg::addrT addr,
                           memPkg::wordT wdata);
        int n;
        n = 0;
        dataIn = '{isStore: write, len: len, addr: addr, wdata: wdata};
        dataValid = 1'b1;
        while (!dataReady) begin
            @(negedge clk);
            n++;
            if (n > limit) abortRun("dataReady");
        end
        @(negedge clk);
        dataValid = 1'b0;
    endtask

    task automatic store(memPkg::accessLen len, memPkg::addrT addr, memPkg::wordT wdata);
        int n;
        n = 0;
        sendReq(1'b1, len, addr, wdata);
        for (int i = 0; i < numBytes(len); i++) begin
            model[addr[11:0] + i] = wdata[8*i +: 8];
        end
        while (!dataReady) begin
            @(negedge clk);
            n++;
            if (n > limit) abortRun("a store to finish");
        end
    endtask

    task automatic load(memPkg::accessLen len, memPkg::addrT addr);
        int n;
        n = 0;
        sendReq(1'b0, len, addr, '0);
        while (!dataDone) begin
            @(negedge clk);
            n++;
            if (n > limit) abortRun("dataDone");
        end
        checkValue("load data", rdata, modelRead(addr, numBytes(len)));
        @(negedge clk);
        checkValue("done pulse length", dataDone, 1'b0);
    endtask

    task automatic redirect(memPkg::addrT pc);
        redirectValid = 1'b1;
        redirectPc = pc;
        @(negedge clk);
        redirectValid = 1'b0;
    endtask

    // instReady is high only for one handshake
    task automatic takeInst(memPkg::addrT pc);
        int n;
        n = 0;
        instReady = 1'b1;
        while (!instValid) begin
            @(negedge clk);
            n++;
            if (n > limit) abortRun("instValid");
        end
        checkValue("instPc", instPc, pc);
        checkValue("instWord", instWord, modelRead(pc, 4));
        @(negedge clk);
        instReady = 1'b0;
    endtask

    task automatic testWords();
        for (int i = 0; i < 6; i++) begin
            store(memPkg::lenWord, 32'h40 + 8*i, nextRand());
        end
        for (int i = 0; i < 6; i++) begin
            load(memPkg::lenWord, 32'h40 + 8*i);
        end
    endtask

    task automatic testNarrow();
        store(memPkg::lenWord, 32'h80, 32'h11223344);
        store(memPkg::lenByte, 32'h81, 32'h000000AB);
        store(memPkg::lenHalf, 32'h82, 32'h0000CDEF);
        load(memPkg::lenByte, 32'h81);
        load(memPkg::lenHalf, 32'h82);
        load(memPkg::lenByte, 32'h80);
        load(memPkg::lenWord, 32'h80);
    endtask

    task automatic testFetch();
        for (int i = 0; i < 16; i++) begin
            store(memPkg::lenWord, 32'h200 + 4*i, nextRand());
        end
        redirect(32'h200);
        for (int i = 0; i < 6; i++) begin
            takeInst(32'h200 + 4*i);
        end
        // the fetch after 0x214 is dropped
        redirect(32'h220);
        takeInst(32'h220);
    endtask

    task automatic testBackpressure();
        int n;
        n = 0;
        while (!instValid) begin
            @(negedge clk);
            n++;
            if (n > limit) abortRun("the held instruction");
        end
        repeat (20) begin
            @(negedge clk);
            checkValue("held instValid", instValid, 1'b1);
            checkValue("held instPc", instPc, 32'h224);
            checkValue("held instWord", instWord, modelRead(32'h224, 4));
        end
        takeInst(32'h224);
        // loads race the next fetch
        for (int i = 0; i < 3; i++) begin
            load(memPkg::lenWord, 32'h40 + 8*i);
            takeInst(32'h228 + 4*i);
        end
    endtask

    task automatic testStall();
        int stall;
        int n;
        n = 0;
        stall = 1 + nextRand() % 8;
        store(memPkg::lenWord, 32'h90, nextRand());
        sendReq(1'b0, memPkg::lenWord, 32'h90, '0);
        @(negedge clk);
        ioFull = 1'b1;
        repeat (stall) begin
            @(negedge clk);
            checkValue("done during stall", dataDone, 1'b0);
        end
        ioFull = 1'b0;
        @(negedge clk);
        while (!dataDone) begin
            @(negedge clk);
            n++;
            if (n > limit) abortRun("dataDone after the stall");
        end
        checkValue("stalled load", rdata, modelRead(32'h90, 4));
        @(negedge clk);
    endtask

    task automatic testRandom();
        logic [31:0] r;
        memPkg::accessLen len;
        memPkg::addrT addr;
        for (int i = 0; i < 16; i++) begin
            store(memPkg::lenWord, 32'h300 + 4*i, nextRand());
        end
        for (int i = 0; i < 40; i++) begin
            r = nextRand();
            len = memPkg::accessLen'((r[25:24] == 2'd3) ? 2'd2 : r[25:24]);
            case (len)
                memPkg::lenByte: addr = 32'h300 + {r[31:28], r[27:26]};
                memPkg::lenHalf: addr = 32'h300 + {r[31:28], r[27], 1'b0};
                default: addr = 32'h300 + {r[31:28], 2'b00};
            endcase
            if (r[23]) begin
                store(len, addr, nextRand());
            end else begin
                load(len, addr);
            end
        end
    endtask

    initial begin
        int n;
        n = 0;
        ioFull = 1'b0;
        dataValid = 1'b0;
        dataIn = '0;
        redirectValid = 1'b0;
        redirectPc = '0;
        instReady = 1'b0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > limit) abortRun("reset release");
            if (rst === 1'b1) begin
                checkValue("dataReady in reset", dataReady, 1'b0);
            end
        end
        checkValue("instValid after reset", instValid, 1'b0);
        checkValue("dataDone after reset", dataDone, 1'b0);
        testWords();
        testNarrow();
        testFetch();
        testBackpressure();
        testStall();
        testRandom();
        $display("%0d check errors, %0d assertion failures", errors,
                 memSubsys_inst.propsInst.failures);
        if (errors == 0 && memSubsys_inst.propsInst.failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- tests/memSubsys_props.sv
`timescale 1ns/1ps

module memSubsysProps (
    input logic         clk,
    input logic         rst,
    input logic         ioFull,
    input logic         dataReady,
    input logic         fetchReady,
    input logic         dataDone,
    input logic         fetchDone,
    input logic         redirectValid,
    input logic         instValid,
    input logic         instReady,
    input memPkg::wordT instWord,
    input memPkg::addrT instPc
);

    int failures = 0;

    stallNoReady: assert property (@(posedge clk) disable iff (rst)
        ioFull |-> !dataReady && !fetchReady)
    else begin
        $error("request ready high while ioFull is set");
        failures++;
    end

    stallNoDone: assert property (@(posedge clk) disable iff (rst)
        ioFull |-> !dataDone && !fetchDone)
    else begin
        $error("done pulse while ioFull is set");
        failures++;
    end

    // a redirect is allowed to drop the held instruction
    instHold: assert property (@(posedge clk) disable iff (rst)
        instValid && !instReady && !redirectValid
        |=> instValid && $stable(instWord) && $stable(instPc))
    else begin
        $error("held instruction changed while instReady was low");
        failures++;
    end

endmodule

bind memSubsys memSubsysProps propsInst (.*);
